//--- verilog.f
source/spi_pkg.sv
source/spi_cmd_if.sv
source/payload_fifo.sv
source/axil_cmd_port.sv
source/spi_frame_engine.sv
source/spi_axil_top.sv
tb/spi_device_model.sv
tb/tb_spi_axil.sv

//--- Bender.yml
package:
  name: spi_axil

sources:
  - files:
      - source/spi_pkg.sv
      - source/spi_cmd_if.sv
      - source/payload_fifo.sv
      - source/axil_cmd_port.sv
      - source/spi_frame_engine.sv
      - source/spi_axil_top.sv
  - target: test
    files:
      - tb/spi_device_model.sv
      - tb/tb_spi_axil.sv

//--- tb/tb_spi_axil.sv
`timescale 1ns/1ps

module tb_spi_axil
  import spi_pkg::*;
();

  localparam int CLK_DIV        = 4;
  localparam int FIFO_DEPTH     = 4;
  localparam int TIMEOUT_CYCLES = 20000;

  logic        clk = 1'b0;
  logic        rst_n;
  logic [3:0]  s_awaddr;
  logic        s_awvalid;
  logic        s_awready;
  logic [31:0] s_wdata;
  logic        s_wvalid;
  logic        s_wready;
  logic [1:0]  s_bresp;
  logic        s_bvalid;
  logic        s_bready;
  logic [3:0]  s_araddr;
  logic        s_arvalid;
  logic        s_arready;
  logic [31:0] s_rdata;
  logic [1:0]  s_rresp;
  logic        s_rvalid;
  logic        s_rready;
  logic        sclk;
  logic        cs;
  logic        mosi;
  logic        miso;

  logic [31:0] lfsr = 32'h1fa1;
  logic [7:0]  exp_regs [8];
  int          error_cnt = 0;
  int          cycle_cnt = 0;

  // frame monitor state, updated at the falling clk edge.
  logic        sclk_prev = 1'b0;
  logic        cs_prev = 1'b1;
  int          edge_cnt = 0;
  int          last_edges = 0;
  logic [19:0] mosi_bits = '0;
  logic [19:0] last_mosi = '0;
  int          frame_starts = 0;
  int          frame_ends = 0;

  spi_axil_top #(.CLK_DIV(CLK_DIV), .FIFO_DEPTH(FIFO_DEPTH)) spi_axil_top_inst (.*);

  spi_device_model spi_device_model_inst (.sclk(sclk), .cs(cs), .mosi(mosi), .miso(miso));

  always #50 clk = ~clk;

  always @(posedge clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TB FAILED");
      $fatal(1, "simulation timed out");
    end
  end

  always @(negedge clk)
  begin
    sclk_prev <= sclk;
    cs_prev   <= cs;
    if (!cs && sclk && !sclk_prev)
    begin
      edge_cnt  <= edge_cnt + 1;
      mosi_bits <= {mosi_bits[18:0], mosi};
    end
    if (cs_prev && !cs)
    begin
      frame_starts <= frame_starts + 1;
      edge_cnt     <= 0;
      mosi_bits    <= '0;
    end
    if (!cs_prev && cs)
    begin
      frame_ends <= frame_ends + 1;
      last_edges <= edge_cnt;
      last_mosi  <= mosi_bits;
    end
  end

  // ********************
  // helpers
  // ********************

  // x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_byte(output logic [7:0] b);
    for (int i = 0; i < 8; i++)
    begin
      lfsr = lfsr_step(lfsr);
      b    = {b[6:0], lfsr[0]};
    end
  endtask

  task automatic check_eq(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    if (expected !== actual)
    begin
      error_cnt = error_cnt + 1;
      $display("** Error: %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
      $display("TB FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // the bus tasks start and end 1 ns after a rising edge.
  task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
    logic done;
    s_awaddr  = addr;
    s_wdata   = data;
    s_awvalid = 1'b1;
    s_wvalid  = 1'b1;
    done      = 1'b0;
    while (!done)
    begin
      @(negedge clk);
      done = s_awready && s_wready;
      @(posedge clk);
      #1;
    end
    s_awvalid = 1'b0;
    s_wvalid  = 1'b0;
    s_bready  = 1'b1;
    done      = 1'b0;
    while (!done)
    begin
      @(negedge clk);
      done = s_bvalid;
      resp = s_bresp;
      @(posedge clk);
      #1;
    end
    s_bready = 1'b0;
  endtask

  task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    logic done;
    s_araddr  = addr;
    s_arvalid = 1'b1;
    done      = 1'b0;
    while (!done)
    begin
      @(negedge clk);
      done = s_arready;
      @(posedge clk);
      #1;
    end
    s_arvalid = 1'b0;
    s_rready  = 1'b1;
    done      = 1'b0;
    while (!done)
    begin
      @(negedge clk);
      done = s_rvalid;
      data = s_rdata;
      resp = s_rresp;
      @(posedge clk);
      #1;
    end
    s_rready = 1'b0;
  endtask

  function automatic logic [31:0] cmd_word(input logic wr, input logic [2:0] addr,
                                           input logic [7:0] data);
    return {20'd0, wr, addr, data};
  endfunction

  task automatic wait_frame_end(input int ends_before);
    while (frame_ends == ends_before)
      @(negedge clk);
    @(posedge clk);
    #1;
  endtask

  // ********************
  // tests
  // ********************

  task automatic test_status_after_reset();
    logic [31:0] data;
    logic [1:0]  resp;
    axil_read(REG_STATUS, data, resp);
    check_eq("status_after_reset resp", RESP_OKAY, resp);
    check_eq("status_after_reset status", 32'h2, data);
    axil_read(REG_RDATA, data, resp);
    check_eq("status_after_reset rdata", 32'h0, data);
  endtask

  task automatic test_write_read_back();
    logic [31:0] data;
    logic [1:0]  resp;
    logic [7:0]  b;
    for (int a = 0; a < 8; a++)
    begin
      random_byte(b);
      exp_regs[a] = b;
      axil_write(REG_CMD, cmd_word(1'b1, 3'(a), b), resp);
      check_eq("write_read_back write resp", RESP_OKAY, resp);
    end
    for (int a = 0; a < 8; a++)
    begin
      axil_write(REG_CMD, cmd_word(1'b0, 3'(a), 8'h00), resp);
      check_eq("write_read_back read resp", RESP_OKAY, resp);
      // wait for busy and rsp_empty to clear.
      do
        axil_read(REG_STATUS, data, resp);
      while (data[2:1] != 2'b00);
      axil_read(REG_RDATA, data, resp);
      check_eq("write_read_back rdata resp", RESP_OKAY, resp);
      check_eq("write_read_back rdata", {23'd0, 1'b1, exp_regs[a]}, data);
    end
  endtask

  task automatic test_frame_shape();
    logic [31:0] data;
    logic [1:0]  resp;
    logic [7:0]  b;
    int          ends0;
    random_byte(b);
    exp_regs[5] = b;
    ends0       = frame_ends;
    axil_write(REG_CMD, cmd_word(1'b1, 3'd5, b), resp);
    wait_frame_end(ends0);
    check_eq("frame_shape write edges", 12, last_edges);
    check_eq("frame_shape write mosi", cmd_word(1'b1, 3'd5, b), {20'd0, last_mosi[11:0]});
    ends0 = frame_ends;
    axil_write(REG_CMD, cmd_word(1'b0, 3'd5, 8'h00), resp);
    wait_frame_end(ends0);
    check_eq("frame_shape read edges", 20, last_edges);
    check_eq("frame_shape read mosi", cmd_word(1'b0, 3'd5, 8'h00), {20'd0, last_mosi[19:8]});
    axil_read(REG_RDATA, data, resp);
    check_eq("frame_shape rdata", {23'd0, 1'b1, b}, data);
  endtask

  task automatic test_burst_backpressure();
    logic [31:0] data;
    logic [1:0]  resp;
    for (int i = 0; i < FIFO_DEPTH + 2; i++)
    begin
      axil_write(REG_CMD, cmd_word(1'b0, 3'(i), 8'h00), resp);
      check_eq("burst_backpressure write resp", RESP_OKAY, resp);
    end
    for (int i = 0; i < FIFO_DEPTH + 2; i++)
    begin
      do
        axil_read(REG_RDATA, data, resp);
      while (!data[8]);
      check_eq("burst_backpressure rdata", {23'd0, 1'b1, exp_regs[i]}, data);
    end
  endtask

  task automatic test_bad_address();
    logic [31:0] data;
    logic [1:0]  resp;
    int          starts0;
    starts0 = frame_starts;
    axil_write(4'hc, cmd_word(1'b1, 3'd1, 8'h5a), resp);
    check_eq("bad_address write resp", RESP_SLVERR, resp);
    axil_read(4'hc, data, resp);
    check_eq("bad_address read resp", RESP_SLVERR, resp);
    check_eq("bad_address read data", 32'h0, data);
    repeat (4 * CLK_DIV) @(posedge clk);
    #1;
    check_eq("bad_address frame starts", starts0, frame_starts);
  endtask

  initial
  begin
    rst_n     = 1'b0;
    s_awaddr  = '0;
    s_awvalid = 1'b0;
    s_wdata   = '0;
    s_wvalid  = 1'b0;
    s_bready  = 1'b0;
    s_araddr  = '0;
    s_arvalid = 1'b0;
    s_rready  = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    test_status_after_reset();
    test_write_read_back();
    test_frame_shape();
    test_burst_backpressure();
    test_bad_address();
    if (error_cnt == 0)
    begin
      $display("TB PASSED");
    end
    else
    begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- tb/spi_device_model.sv
`timescale 1ns/1ps

module spi_device_model
  import spi_pkg::*;
(
  input  logic sclk,
  input  logic cs,
  input  logic mosi,
  output logic miso
);

  logic [DATA_WIDTH-1:0] regs [8];
  logic [CMD_WIDTH-1:0]  cmd_sr;
  logic [READ_WIDTH-1:0] tx_sr;
  int                    bit_cnt;

  initial
  begin
    for (int i = 0; i < 8; i++)
      regs[i] = '0;
    tx_sr   = '0;
    miso    = 1'b0;
    bit_cnt = 0;
  end

  always @(negedge cs)
  begin
    bit_cnt = 0;
    miso    = 1'b0;
  end

  // mosi is sampled on the rising edge of sclk.
  always @(posedge sclk)
  begin
    if (!cs)
    begin
      if (bit_cnt < CMD_WIDTH)
        cmd_sr = {cmd_sr[CMD_WIDTH-2:0], mosi};
      bit_cnt = bit_cnt + 1;
      if (bit_cnt == CMD_WIDTH)
      begin
        if (cmd_sr[CMD_WIDTH-1])
        begin
          regs[cmd_sr[10:8]] = cmd_sr[7:0];
          tx_sr              = '0;
        end
        else
          tx_sr = regs[cmd_sr[10:8]];
      end
    end
  end

  // read data leaves MSB first, one bit per falling edge after the command.
  always @(negedge sclk)
  begin
    if (!cs && bit_cnt >= CMD_WIDTH && bit_cnt < CMD_WIDTH + READ_WIDTH)
    begin
      miso  = tx_sr[READ_WIDTH-1];
      tx_sr = tx_sr << 1;
    end
  end

endmodule

//--- source/spi_axil_top.sv
`timescale 1ns/1ps

module spi_axil_top
  import spi_pkg::*;
#(
  parameter int CLK_DIV    = 4,
  parameter int FIFO_DEPTH = 4
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [3:0]  s_awaddr,
  input  logic        s_awvalid,
  output logic        s_awready,
  input  logic [31:0] s_wdata,
  input  logic        s_wvalid,
  output logic        s_wready,
  output logic [1:0]  s_bresp,
  output logic        s_bvalid,
  input  logic        s_bready,
  input  logic [3:0]  s_araddr,
  input  logic        s_arvalid,
  output logic        s_arready,
  output logic [31:0] s_rdata,
  output logic [1:0]  s_rresp,
  output logic        s_rvalid,
  input  logic        s_rready,
  output logic        sclk,
  output logic        cs,
  output logic        mosi,
  input  logic        miso
);

  spi_cmd_if  cmd_if ();

  logic       cmd_push;
  spi_cmd_t   cmd_data;
  spi_cmd_t   cmd_head;
  logic       cmd_full;
  logic       cmd_empty;
  logic       rsp_push;
  read_data_t rsp_wdata;
  read_data_t rsp_head;
  logic       rsp_pop;
  logic       rsp_full;
  logic       rsp_empty;
  logic       busy;

  // the command FIFO head drives the source side of the engine link.
  assign cmd_if.valid    = !cmd_empty;
  assign cmd_if.is_write = cmd_head.is_write;
  assign cmd_if.addr     = cmd_head.addr;
  assign cmd_if.wdata    = cmd_head.wdata;

  axil_cmd_port axil_cmd_port_inst (.*, .rsp_data(rsp_head));

  payload_fifo #(.T(spi_cmd_t), .DEPTH(FIFO_DEPTH)) cmd_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (cmd_push),
    .push_data (cmd_data),
    .pop       (cmd_if.valid && cmd_if.ready),
    .pop_data  (cmd_head),
    .full      (cmd_full),
    .empty     (cmd_empty)
  );

  payload_fifo #(.T(read_data_t), .DEPTH(FIFO_DEPTH)) rsp_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (rsp_push),
    .push_data (rsp_wdata),
    .pop       (rsp_pop),
    .pop_data  (rsp_head),
    .full      (rsp_full),
    .empty     (rsp_empty)
  );

  spi_frame_engine #(.CLK_DIV(CLK_DIV)) spi_frame_engine_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd      (cmd_if.dst),
    .rsp_full (rsp_full),
    .rsp_push (rsp_push),
    .rsp_data (rsp_wdata),
    .busy     (busy),
    .sclk     (sclk),
    .cs       (cs),
    .mosi     (mosi),
    .miso     (miso)
  );

endmodule

//--- source/spi_frame_engine.sv
`timescale 1ns/1ps

module spi_frame_engine
  import spi_pkg::*;
#(
  parameter int CLK_DIV = 4
) (
  input  logic       clk,
  input  logic       rst_n,
  spi_cmd_if.dst     cmd,
  input  logic       rsp_full,
  output logic       rsp_push,
  output read_data_t rsp_data,
  output logic       busy,
  output logic       sclk,
  output logic       cs,
  output logic       mosi,
  input  logic       miso
);

  localparam int HW         = $clog2(CLK_DIV);
  localparam int FRAME_BITS = CMD_WIDTH + READ_WIDTH;
  localparam int BW         = $clog2(FRAME_BITS + 1);

  typedef enum logic [2:0] {IDLE, LEAD, SHIFT, CAPTURE, TRAIL} state_t;

  state_t                 state;
  logic [HW-1:0]          hcnt;
  logic [BW-1:0]          bcnt;
  logic [CMD_WIDTH-1:0]   sr;
  read_data_t             rx;
  logic                   is_rd;
  logic                   tick;
  logic                   edge_up;
  logic                   edge_dn;

  assign tick    = (hcnt == HW'(CLK_DIV - 1));
  assign edge_up = (state == SHIFT || state == CAPTURE) && tick && !sclk;
  assign edge_dn = (state == SHIFT || state == CAPTURE) && tick && sclk;

  // a read waits while the response FIFO has no room for its result.
  assign cmd.ready = (state == IDLE) && (cmd.is_write || !rsp_full);

  assign mosi     = sr[CMD_WIDTH-1];
  assign busy     = (state != IDLE);
  assign rsp_data = rx;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= IDLE;
      hcnt     <= '0;
      bcnt     <= '0;
      sr       <= '0;
      is_rd    <= 1'b0;
      sclk     <= 1'b0;
      cs       <= 1'b1;
      rsp_push <= 1'b0;
    end
    else
    begin
      rsp_push <= 1'b0;
      if (state == IDLE || tick)
        hcnt <= '0;
      else
        hcnt <= hcnt + 1'b1;
      case (state)
        IDLE:
        begin
          if (cmd.valid && cmd.ready)
          begin
            state <= LEAD;
            cs    <= 1'b0;
            sr    <= {cmd.is_write, cmd.addr, cmd.wdata};
            is_rd <= !cmd.is_write;
            bcnt  <= '0;
          end
        end
        LEAD:
        begin
          if (tick)
          begin
            sclk  <= 1'b1;
            state <= SHIFT;
          end
        end
        SHIFT, CAPTURE:
        begin
          if (edge_up)
            sclk <= 1'b1;
          if (edge_dn)
          begin
            // mosi moves on to the next bit at the falling edge.
            sclk <= 1'b0;
            sr   <= sr << 1;
            bcnt <= bcnt + 1'b1;
            if (state == SHIFT && bcnt == BW'(CMD_WIDTH - 1))
              state <= is_rd ? CAPTURE : TRAIL;
            else if (bcnt == BW'(FRAME_BITS - 1))
              state <= TRAIL;
          end
        end
        TRAIL:
        begin
          if (cs)
            state <= IDLE;
          else if (tick)
          begin
            cs       <= 1'b1;
            rsp_push <= is_rd;
          end
        end
        default:
          state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (edge_up && state == CAPTURE)
      rx <= {rx[READ_WIDTH-2:0], miso};
  end

  // ********************
  // frame checks
  // ********************

  a_cs_frame: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(cs) |-> !cs throughout
      (bcnt == (is_rd ? BW'(FRAME_BITS) : BW'(CMD_WIDTH)))[->1])
    else $error("cs left low state before the frame ended");

  a_sclk_cs: assert property (@(posedge clk) disable iff (!rst_n)
    !$stable(sclk) |-> !cs)
    else $error("sclk toggled while cs was high");

endmodule

//--- source/axil_cmd_port.sv
`timescale 1ns/1ps

module axil_cmd_port
  import spi_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic [3:0]  s_awaddr,
  input  logic        s_awvalid,
  output logic        s_awready,
  input  logic [31:0] s_wdata,
  input  logic        s_wvalid,
  output logic        s_wready,
  output logic [1:0]  s_bresp,
  output logic        s_bvalid,
  input  logic        s_bready,
  input  logic [3:0]  s_araddr,
  input  logic        s_arvalid,
  output logic        s_arready,
  output logic [31:0] s_rdata,
  output logic [1:0]  s_rresp,
  output logic        s_rvalid,
  input  logic        s_rready,
  input  logic        cmd_full,
  output logic        cmd_push,
  output spi_cmd_t    cmd_data,
  input  read_data_t  rsp_data,
  input  logic        rsp_empty,
  output logic        rsp_pop,
  input  logic        busy
);

  logic        aw_is_cmd;
  logic        wr_go;
  logic        rd_go;
  logic [31:0] rd_word;
  logic [1:0]  rd_resp;

  // ********************
  // write channel
  // ********************

  // address and data are taken together, and a command write waits for FIFO space.
  assign aw_is_cmd = (s_awaddr == REG_CMD);
  assign wr_go     = s_awvalid && s_wvalid && !s_bvalid && (!aw_is_cmd || !cmd_full);
  assign s_awready = wr_go;
  assign s_wready  = wr_go;
  assign cmd_push  = wr_go && aw_is_cmd;
  assign cmd_data  = spi_cmd_t'(s_wdata[CMD_WIDTH-1:0]);

  // ********************
  // read channel
  // ********************

  assign s_arready = !s_rvalid;
  assign rd_go     = s_arvalid && s_arready;
  assign rsp_pop   = rd_go && (s_araddr == REG_RDATA) && !rsp_empty;

  always_comb
  begin
    rd_word = '0;
    rd_resp = RESP_OKAY;
    case (s_araddr)
      REG_RDATA:
      begin
        if (!rsp_empty)
          rd_word = {23'd0, 1'b1, rsp_data};
      end
      REG_STATUS:
        rd_word = {29'd0, busy, rsp_empty, cmd_full};
      default:
        rd_resp = RESP_SLVERR;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      s_bvalid <= 1'b0;
      s_rvalid <= 1'b0;
    end
    else
    begin
      if (wr_go)
        s_bvalid <= 1'b1;
      else if (s_bready)
        s_bvalid <= 1'b0;
      if (rd_go)
        s_rvalid <= 1'b1;
      else if (s_rready)
        s_rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr_go)
      s_bresp <= aw_is_cmd ? RESP_OKAY : RESP_SLVERR;
    if (rd_go)
    begin
      s_rdata <= rd_word;
      s_rresp <= rd_resp;
    end
  end

endmodule

//--- source/payload_fifo.sv
`timescale 1ns/1ps

module payload_fifo #(
  parameter type T     = logic [7:0],
  parameter int  DEPTH = 4
) (
  input  logic clk,
  input  logic rst_n,
  input  logic push,
  input  T     push_data,
  input  logic pop,
  output T     pop_data,
  output logic full,
  output logic empty
);

  localparam int AW = $clog2(DEPTH);

  T           mem [DEPTH];
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;

  // the extra top bit tells a full buffer from an empty one.
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

  // head entry is visible without a read delay.
  assign pop_data = mem[rd_ptr[AW-1:0]];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr[AW-1:0]] <= push_data;
  end

  // ********************
  // usage checks
  // ********************

  a_push_full: assert property (@(posedge clk) disable iff (!rst_n) !(push && full))
    else $error("push into a full FIFO");

  a_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) !(pop && empty))
    else $error("pop from an empty FIFO");

endmodule

//--- source/spi_cmd_if.sv
`timescale 1ns/1ps

interface spi_cmd_if
  import spi_pkg::*;
();

  logic                  valid;
  logic                  ready;
  logic                  is_write;
  logic [ADDR_WIDTH-1:0] addr;
  logic [DATA_WIDTH-1:0] wdata;

  // the source holds the fields stable while valid is high and ready is low.
  modport src (
    output valid, is_write, addr, wdata,
    input  ready
  );

  modport dst (
    input  valid, is_write, addr, wdata,
    output ready
  );

endinterface

//--- source/spi_pkg.sv
package spi_pkg;

  // ********************
  // command frame format
  // ********************

  localparam int ADDR_WIDTH = 3;
  localparam int DATA_WIDTH = 8;
  localparam int CMD_WIDTH  = 12;
  localparam int READ_WIDTH = 8;

  // bit 11 selects write (1) or read (0), then the register address and write data.
  typedef struct packed {
    logic                  is_write;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] wdata;
  } spi_cmd_t;

  typedef logic [READ_WIDTH-1:0] read_data_t;

  // ********************
  // register map
  // ********************

  localparam logic [3:0] REG_CMD    = 4'h0;
  localparam logic [3:0] REG_RDATA  = 4'h4;
  localparam logic [3:0] REG_STATUS = 4'h8;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage
